//--- include/rv64_cfg.svh
// core-wide sizes for the decode stage
// RAS_DEPTH must be a power of two and at least 2
// link register numbers follow the standard calling convention

`ifndef RV64_CFG_SVH
`define RV64_CFG_SVH

// data and address width
`define XLEN 64

// return address stack entries
`define RAS_DEPTH 8

// registers treated as link registers for call and return detection
`define LINK_RA 5'd1
`define LINK_T0 5'd5

`endif

//--- rtl/rv64_pkg.sv
// shared types of the RV64I decode stage
// widths come from rv64_cfg.svh
`default_nettype none

`include "rv64_cfg.svh"

package rv64_pkg;

	// views of one 32-bit instruction word
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} instr_i_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} instr_s_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
		instr_s_t s;
	} instr_u;

	// one value per decoded operation, grouped by instruction kind
	typedef enum logic [5:0] {
		op_lui, op_auipc, op_jal, op_jalr,
		op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld,
		op_sb, op_sh, op_sw, op_sd,
		op_addi, op_addiw, op_slti, op_sltiu, op_xori, op_ori, op_andi,
		op_slli, op_slliw, op_srli, op_srliw, op_srai, op_sraiw,
		op_add, op_addw, op_sub, op_subw, op_sll, op_sllw, op_slt, op_sltu,
		op_xor, op_srl, op_srlw, op_sra, op_sraw, op_or, op_and,
		op_fence, op_fence_i,
		op_ecall, op_ebreak,
		op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci,
		op_none
	} op_e;

	typedef enum logic [2:0] {
		cls_intcomp,
		cls_ctltran,
		cls_lodstru,
		cls_envcall,
		cls_illegal
	} exe_class_e;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		op_e              op;
		exe_class_e       cls;
		logic [4:0]       rd;
		logic [4:0]       rs1;
		logic [4:0]       rs2;
		logic [`XLEN-1:0] imm;
		logic             is_word;
		logic             is_call;
		logic             is_return;
	} micro_op_t;

endpackage

`default_nettype wire

//--- rtl/decoder.sv
// combinational RV64I decoder, one word in, one micro-op out
// no compressed, floating point, fused multiply-add or AMO support
// register fields are passed raw for every format
// unmatched words give op_none, cls_illegal and a zero immediate
`timescale 1ns/1ns
`default_nettype none

`include "rv64_cfg.svh"

module decoder (
	input  rv64_pkg::instr_u    instr_i,
	input  logic [`XLEN-1:0]    pc_i,
	output rv64_pkg::micro_op_t micro_op_o
);

	wire [6:0]  opc   = instr_i.r.opcode;
	wire [2:0]  f3    = instr_i.r.funct3;
	wire [6:0]  f7    = instr_i.r.funct7;
	wire [11:0] imm12 = instr_i.i.imm12;

	// opcode bit groups
	wire opc_xxxxx11 = (opc[1:0] == 2'b11);

	wire opc_xx000xx = (opc[4:2] == 3'b000);
	wire opc_xx001xx = (opc[4:2] == 3'b001);
	wire opc_xx011xx = (opc[4:2] == 3'b011);
	wire opc_xx100xx = (opc[4:2] == 3'b100);
	wire opc_xx101xx = (opc[4:2] == 3'b101);
	wire opc_xx110xx = (opc[4:2] == 3'b110);

	wire opc_00xxxxx = (opc[6:5] == 2'b00);
	wire opc_01xxxxx = (opc[6:5] == 2'b01);
	wire opc_11xxxxx = (opc[6:5] == 2'b11);

	// major opcode groups, the 10xxxxx row (fused multiply-add) stays unmatched
	wire grp_load     = opc_00xxxxx & opc_xx000xx & opc_xxxxx11;
	wire grp_misc_mem = opc_00xxxxx & opc_xx011xx & opc_xxxxx11;
	wire grp_op_imm   = opc_00xxxxx & opc_xx100xx & opc_xxxxx11;
	wire grp_auipc    = opc_00xxxxx & opc_xx101xx & opc_xxxxx11;
	wire grp_op_imm32 = opc_00xxxxx & opc_xx110xx & opc_xxxxx11;
	wire grp_store    = opc_01xxxxx & opc_xx000xx & opc_xxxxx11;
	wire grp_op       = opc_01xxxxx & opc_xx100xx & opc_xxxxx11;
	wire grp_lui      = opc_01xxxxx & opc_xx101xx & opc_xxxxx11;
	wire grp_op_32    = opc_01xxxxx & opc_xx110xx & opc_xxxxx11;
	wire grp_branch   = opc_11xxxxx & opc_xx000xx & opc_xxxxx11;
	wire grp_jalr     = opc_11xxxxx & opc_xx001xx & opc_xxxxx11;
	wire grp_jal      = opc_11xxxxx & opc_xx011xx & opc_xxxxx11;
	wire grp_system   = opc_11xxxxx & opc_xx100xx & opc_xxxxx11;

	wire f7_base = (f7 == 7'b0000000);
	wire f7_alt  = (f7 == 7'b0100000);

	// sign-extended immediates per format
	wire [`XLEN-1:0] imm_i = {{(`XLEN-12){imm12[11]}}, imm12};
	wire [`XLEN-1:0] imm_s = {{(`XLEN-12){instr_i.s.imm_hi[6]}},
		instr_i.s.imm_hi, instr_i.s.imm_lo};
	wire [`XLEN-1:0] imm_b = {{(`XLEN-13){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi[6],
		instr_i.s.imm_lo[0], instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
	wire [`XLEN-1:0] imm_u = {{(`XLEN-32){imm12[11]}}, imm12, instr_i.i.rs1,
		instr_i.i.funct3, 12'b0};
	wire [`XLEN-1:0] imm_j = {{(`XLEN-21){imm12[11]}}, imm12[11], instr_i.i.rs1,
		instr_i.i.funct3, imm12[0], imm12[10:1], 1'b0};

	rv64_pkg::op_e        op;
	rv64_pkg::exe_class_e cls;
	logic [`XLEN-1:0]     imm;
	logic                 is_word;
	logic                 rd_link;
	logic                 rs1_link;
	logic                 is_call;
	logic                 is_return;

	// operation select from group, funct3, funct7 and imm12
	always_comb begin
		op = rv64_pkg::op_none;
		if (grp_lui) begin
			op = rv64_pkg::op_lui;
		end else if (grp_auipc) begin
			op = rv64_pkg::op_auipc;
		end else if (grp_jal) begin
			op = rv64_pkg::op_jal;
		end else if (grp_jalr) begin
			if (f3 == 3'b000)
				op = rv64_pkg::op_jalr;
		end else if (grp_branch) begin
			case (f3)
				3'b000: op = rv64_pkg::op_beq;
				3'b001: op = rv64_pkg::op_bne;
				3'b100: op = rv64_pkg::op_blt;
				3'b101: op = rv64_pkg::op_bge;
				3'b110: op = rv64_pkg::op_bltu;
				3'b111: op = rv64_pkg::op_bgeu;
				default: op = rv64_pkg::op_none;
			endcase
		end else if (grp_load) begin
			case (f3)
				3'b000: op = rv64_pkg::op_lb;
				3'b001: op = rv64_pkg::op_lh;
				3'b010: op = rv64_pkg::op_lw;
				3'b011: op = rv64_pkg::op_ld;
				3'b100: op = rv64_pkg::op_lbu;
				3'b101: op = rv64_pkg::op_lhu;
				3'b110: op = rv64_pkg::op_lwu;
				default: op = rv64_pkg::op_none;
			endcase
		end else if (grp_store) begin
			case (f3)
				3'b000: op = rv64_pkg::op_sb;
				3'b001: op = rv64_pkg::op_sh;
				3'b010: op = rv64_pkg::op_sw;
				3'b011: op = rv64_pkg::op_sd;
				default: op = rv64_pkg::op_none;
			endcase
		end else if (grp_op_imm) begin
			// 64-bit shifts take a 6-bit shamt, so only funct7[6:1] is checked
			case (f3)
				3'b000: op = rv64_pkg::op_addi;
				3'b010: op = rv64_pkg::op_slti;
				3'b011: op = rv64_pkg::op_sltiu;
				3'b100: op = rv64_pkg::op_xori;
				3'b110: op = rv64_pkg::op_ori;
				3'b111: op = rv64_pkg::op_andi;
				3'b001: begin
					if (f7[6:1] == 6'b000000)
						op = rv64_pkg::op_slli;
				end
				default: begin
					if (f7[6:1] == 6'b000000)
						op = rv64_pkg::op_srli;
					else if (f7[6:1] == 6'b010000)
						op = rv64_pkg::op_srai;
				end
			endcase
		end else if (grp_op_imm32) begin
			if (f3 == 3'b000)
				op = rv64_pkg::op_addiw;
			else if (f3 == 3'b001 && f7_base)
				op = rv64_pkg::op_slliw;
			else if (f3 == 3'b101 && f7_base)
				op = rv64_pkg::op_srliw;
			else if (f3 == 3'b101 && f7_alt)
				op = rv64_pkg::op_sraiw;
		end else if (grp_op) begin
			if (f7_base) begin
				case (f3)
					3'b000: op = rv64_pkg::op_add;
					3'b001: op = rv64_pkg::op_sll;
					3'b010: op = rv64_pkg::op_slt;
					3'b011: op = rv64_pkg::op_sltu;
					3'b100: op = rv64_pkg::op_xor;
					3'b101: op = rv64_pkg::op_srl;
					3'b110: op = rv64_pkg::op_or;
					default: op = rv64_pkg::op_and;
				endcase
			end else if (f7_alt && f3 == 3'b000) begin
				op = rv64_pkg::op_sub;
			end else if (f7_alt && f3 == 3'b101) begin
				op = rv64_pkg::op_sra;
			end
		end else if (grp_op_32) begin
			if (f7_base && f3 == 3'b000)
				op = rv64_pkg::op_addw;
			else if (f7_alt && f3 == 3'b000)
				op = rv64_pkg::op_subw;
			else if (f7_base && f3 == 3'b001)
				op = rv64_pkg::op_sllw;
			else if (f7_base && f3 == 3'b101)
				op = rv64_pkg::op_srlw;
			else if (f7_alt && f3 == 3'b101)
				op = rv64_pkg::op_sraw;
		end else if (grp_misc_mem) begin
			if (f3 == 3'b000)
				op = rv64_pkg::op_fence;
			else if (f3 == 3'b001)
				op = rv64_pkg::op_fence_i;
		end else if (grp_system) begin
			case (f3)
				3'b000: begin
					if (imm12 == 12'h000)
						op = rv64_pkg::op_ecall;
					else if (imm12 == 12'h001)
						op = rv64_pkg::op_ebreak;
				end
				3'b001: op = rv64_pkg::op_csrrw;
				3'b010: op = rv64_pkg::op_csrrs;
				3'b011: op = rv64_pkg::op_csrrc;
				3'b101: op = rv64_pkg::op_csrrwi;
				3'b110: op = rv64_pkg::op_csrrsi;
				3'b111: op = rv64_pkg::op_csrrci;
				default: op = rv64_pkg::op_none;
			endcase
		end
	end

	// class, immediate format and word flag follow from the operation
	always_comb begin
		cls = rv64_pkg::cls_intcomp;
		imm = '0;
		is_word = 1'b0;
		case (op)
			rv64_pkg::op_lui, rv64_pkg::op_auipc: imm = imm_u;
			rv64_pkg::op_jal: begin
				cls = rv64_pkg::cls_ctltran;
				imm = imm_j;
			end
			rv64_pkg::op_jalr: begin
				cls = rv64_pkg::cls_ctltran;
				imm = imm_i;
			end
			rv64_pkg::op_beq, rv64_pkg::op_bne, rv64_pkg::op_blt,
			rv64_pkg::op_bge, rv64_pkg::op_bltu, rv64_pkg::op_bgeu: begin
				cls = rv64_pkg::cls_ctltran;
				imm = imm_b;
			end
			rv64_pkg::op_lb, rv64_pkg::op_lh, rv64_pkg::op_lw, rv64_pkg::op_ld,
			rv64_pkg::op_lbu, rv64_pkg::op_lhu, rv64_pkg::op_lwu: begin
				cls = rv64_pkg::cls_lodstru;
				imm = imm_i;
			end
			rv64_pkg::op_sb, rv64_pkg::op_sh, rv64_pkg::op_sw, rv64_pkg::op_sd: begin
				cls = rv64_pkg::cls_lodstru;
				imm = imm_s;
			end
			rv64_pkg::op_addi, rv64_pkg::op_slti, rv64_pkg::op_sltiu, rv64_pkg::op_xori,
			rv64_pkg::op_ori, rv64_pkg::op_andi, rv64_pkg::op_slli, rv64_pkg::op_srli,
			rv64_pkg::op_srai: imm = imm_i;
			rv64_pkg::op_addiw, rv64_pkg::op_slliw, rv64_pkg::op_srliw,
			rv64_pkg::op_sraiw: begin
				imm = imm_i;
				is_word = 1'b1;
			end
			rv64_pkg::op_addw, rv64_pkg::op_subw, rv64_pkg::op_sllw,
			rv64_pkg::op_srlw, rv64_pkg::op_sraw: is_word = 1'b1;
			rv64_pkg::op_fence, rv64_pkg::op_fence_i, rv64_pkg::op_ecall,
			rv64_pkg::op_ebreak, rv64_pkg::op_csrrw, rv64_pkg::op_csrrs,
			rv64_pkg::op_csrrc, rv64_pkg::op_csrrwi, rv64_pkg::op_csrrsi,
			rv64_pkg::op_csrrci: cls = rv64_pkg::cls_envcall;
			rv64_pkg::op_none: cls = rv64_pkg::cls_illegal;
			// remaining register-register ops
			default: cls = rv64_pkg::cls_intcomp;
		endcase
	end

	// call and return hints for the return address stack
	assign rd_link   = (instr_i.r.rd == `LINK_RA) || (instr_i.r.rd == `LINK_T0);
	assign rs1_link  = (instr_i.r.rs1 == `LINK_RA) || (instr_i.r.rs1 == `LINK_T0);
	assign is_call   = (op == rv64_pkg::op_jal || op == rv64_pkg::op_jalr) && rd_link;
	assign is_return = (op == rv64_pkg::op_jalr) && rs1_link && !rd_link;

	assign micro_op_o = '{
		pc:        pc_i,
		op:        op,
		cls:       cls,
		rd:        instr_i.r.rd,
		rs1:       instr_i.r.rs1,
		rs2:       instr_i.r.rs2,
		imm:       imm,
		is_word:   is_word,
		is_call:   is_call,
		is_return: is_return
	};

endmodule

`default_nettype wire

//--- rtl/ras.sv
// circular return address stack
// a push to a full stack overwrites the oldest entry
// pop on empty is ignored; push and pop must not be high together
`timescale 1ns/1ns
`default_nettype none

`include "rv64_cfg.svh"

module ras (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             push_i,
	input  logic             pop_i,
	input  logic [`XLEN-1:0] push_addr_i,
	output logic [`XLEN-1:0] top_o,
	output logic             empty_o
);

	localparam int PTR_W = $clog2(`RAS_DEPTH);
	localparam int CNT_W = $clog2(`RAS_DEPTH + 1);

	logic [`XLEN-1:0] stack_mem [`RAS_DEPTH];
	logic [PTR_W-1:0] top_ptr;
	logic [PTR_W-1:0] next_ptr;
	logic [CNT_W-1:0] count;

	// pointer wraps since the depth is a power of two
	assign next_ptr = top_ptr + PTR_W'(1);

	assign top_o   = stack_mem[top_ptr];
	assign empty_o = (count == '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			top_ptr <= '0;
			count   <= '0;
		end else if (push_i) begin
			top_ptr <= next_ptr;
			// count saturates, older entries are lost silently
			if (count != CNT_W'(`RAS_DEPTH))
				count <= count + CNT_W'(1);
		end else if (pop_i && !empty_o) begin
			top_ptr <= top_ptr - PTR_W'(1);
			count   <= count - CNT_W'(1);
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i)
			stack_mem[next_ptr] <= push_addr_i;
	end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
// two-register RV64I decode stage with return target prediction
// latency is exactly two cycles, one result per cycle
// no stall or back-pressure, each output holds for one cycle only
`timescale 1ns/1ns
`default_nettype none

`include "rv64_cfg.svh"

module decode_stage (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                instr_valid_i,
	input  logic [31:0]         instr_i,
	input  logic [`XLEN-1:0]    pc_i,
	output logic                op_valid_o,
	output rv64_pkg::micro_op_t op_o,
	output logic                pred_valid_o,
	output logic [`XLEN-1:0]    pred_target_o
);

	// input register
	logic             in_valid_q;
	rv64_pkg::instr_u in_instr_q;
	logic [`XLEN-1:0] in_pc_q;

	rv64_pkg::micro_op_t dec_uop;

	logic             ras_push;
	logic             ras_pop;
	logic [`XLEN-1:0] ras_top;
	logic             ras_empty;

	// output register
	logic                out_valid_q;
	rv64_pkg::micro_op_t op_q;
	logic                pred_valid_q;
	logic [`XLEN-1:0]    pred_target_q;

	decoder decoder0 (
		.instr_i    (in_instr_q),
		.pc_i       (in_pc_q),
		.micro_op_o (dec_uop)
	);

	// stack update happens in the decode cycle
	assign ras_push = in_valid_q && dec_uop.is_call;
	assign ras_pop  = in_valid_q && dec_uop.is_return;

	ras ras0 (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.push_i      (ras_push),
		.pop_i       (ras_pop),
		.push_addr_i (dec_uop.pc + `XLEN'(4)),
		.top_o       (ras_top),
		.empty_o     (ras_empty)
	);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			in_valid_q   <= 1'b0;
			out_valid_q  <= 1'b0;
			pred_valid_q <= 1'b0;
		end else begin
			in_valid_q   <= instr_valid_i;
			out_valid_q  <= in_valid_q;
			// top is read before this cycle's pop takes effect
			pred_valid_q <= ras_pop && !ras_empty;
		end
	end

	always_ff @(posedge clk_i) begin
		if (instr_valid_i) begin
			in_instr_q <= instr_i;
			in_pc_q    <= pc_i;
		end
		if (in_valid_q) begin
			op_q          <= dec_uop;
			pred_target_q <= ras_top;
		end
	end

	assign op_valid_o    = out_valid_q;
	assign op_o          = op_q;
	assign pred_valid_o  = pred_valid_q;
	assign pred_target_o = pred_target_q;

endmodule

`default_nettype wire

//--- testbench/decode_stage_props.sv
// protocol checks on the decode stage outputs
// assumes a synchronous active high reset of at least two cycles
`timescale 1ns/1ns
`default_nettype none

module decode_stage_props (
	input logic                clk_i,
	input logic                rst_i,
	input logic                instr_valid_i,
	input logic                op_valid_o,
	input logic                pred_valid_o,
	input rv64_pkg::micro_op_t op_o
);

	// a result leaves exactly two cycles after its strobe
	latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
		($past(rst_i, 1) || $past(rst_i, 2) || (op_valid_o == $past(instr_valid_i, 2))))
		else $error("op_valid_o does not follow instr_valid_i by two cycles");

	// predictions only ride on returns
	pred_a: assert property (@(posedge clk_i) disable iff (rst_i)
		pred_valid_o |-> (op_valid_o && op_o.is_return))
		else $error("pred_valid_o high without a valid return");

	reset_a: assert property (@(posedge clk_i)
		$past(rst_i) |-> (!op_valid_o && !pred_valid_o))
		else $error("valid outputs high in the cycle after reset");

endmodule

bind decode_stage decode_stage_props props0 (
	.clk_i         (clk_i),
	.rst_i         (rst_i),
	.instr_valid_i (instr_valid_i),
	.op_valid_o    (op_valid_o),
	.pred_valid_o  (pred_valid_o),
	.op_o          (op_o)
);

`default_nettype wire

//--- testbench/tb_decode_stage.sv
// directed testbench for the RV64I decode stage
// expected micro-ops come from an encoder and a stack model kept in step with issue order
// results are checked at the falling edge and the run stops at the first error
`timescale 1ns/1ns
`default_nettype none

`include "rv64_cfg.svh"

module tb_decode_stage;

	localparam int MAX_CYCLES = 2000;

	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_MISC   = 7'b0001111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_IMM32  = 7'b0011011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OP32   = 7'b0111011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	typedef struct {
		rv64_pkg::micro_op_t uop;
		logic                pred_valid;
		logic [`XLEN-1:0]    pred_target;
		int                  stamp;
	} expect_t;

	logic                clk_i;
	logic                rst_i;
	logic                instr_valid_i;
	logic [31:0]         instr_i;
	logic [`XLEN-1:0]    pc_i;
	logic                op_valid_o;
	rv64_pkg::micro_op_t op_o;
	logic                pred_valid_o;
	logic [`XLEN-1:0]    pred_target_o;

	expect_t          exp_q[$];
	int               cyc = 0;
	logic [`XLEN-1:0] pc = 64'h0000_0000_8000_0000;

	// return stack model
	logic [`XLEN-1:0] ras_mem [`RAS_DEPTH];
	int               ras_top = 0;
	int               ras_count = 0;

	decode_stage dut0 (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.pc_i          (pc_i),
		.op_valid_o    (op_valid_o),
		.op_o          (op_o),
		.pred_valid_o  (pred_valid_o),
		.pred_target_o (pred_target_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	task automatic fail(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	always @(posedge clk_i) begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES)
			fail("timeout, the tests did not finish within the cycle limit");
	end

	task automatic check_micro_op(input string name, input rv64_pkg::micro_op_t got,
		input rv64_pkg::micro_op_t exp);
		if (got !== exp)
			fail($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_pred(input logic got_v, input logic [`XLEN-1:0] got_t,
		input logic exp_v, input logic [`XLEN-1:0] exp_t);
		if (got_v !== exp_v)
			fail($sformatf("mismatch at %0t: pred_valid_o got %b expected %b",
				$time, got_v, exp_v));
		else if (exp_v && got_t !== exp_t)
			fail($sformatf("mismatch at %0t: pred_target_o got %h expected %h",
				$time, got_t, exp_t));
	endtask

	// results leave in issue order at the cycle given by the latency
	always @(negedge clk_i) begin : monitor
		expect_t e;
		if (op_valid_o === 1'b1) begin
			if (exp_q.size() == 0) begin
				fail("op_valid_o pulsed with no instruction outstanding");
			end else begin
				e = exp_q.pop_front();
				if (cyc != e.stamp)
					fail($sformatf("result for pc %h came out at cycle %0d instead of %0d",
						e.uop.pc, cyc, e.stamp));
				check_micro_op("op_o", op_o, e.uop);
				check_pred(pred_valid_o, pred_target_o, e.pred_valid, e.pred_target);
			end
		end else if (pred_valid_o === 1'b1) begin
			fail("pred_valid_o went high without op_valid_o");
		end
	end

	function automatic logic [63:0] sext(input logic [63:0] v, input int bits);
		logic [63:0] sh;
		sh = v << (64 - bits);
		return $signed(sh) >>> (64 - bits);
	endfunction

	function automatic logic [4:0] rreg();
		logic [31:0] t;
		t = $urandom;
		return t[4:0];
	endfunction

	function automatic logic is_link(input logic [4:0] r);
		return (r == 5'd1) || (r == 5'd5);
	endfunction

	// one instruction encoder per format
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	// drives one strobe and queues the expected micro-op and prediction
	task automatic issue(input logic [31:0] word, input rv64_pkg::op_e op,
		input rv64_pkg::exe_class_e cls, input logic [63:0] imm, input logic is_word);
		expect_t e;
		logic    rd_l;
		logic    rs1_l;
		rd_l = is_link(word[11:7]);
		rs1_l = is_link(word[19:15]);
		e.uop.pc = pc;
		e.uop.op = op;
		e.uop.cls = cls;
		e.uop.rd = word[11:7];
		e.uop.rs1 = word[19:15];
		e.uop.rs2 = word[24:20];
		e.uop.imm = imm;
		e.uop.is_word = is_word;
		e.uop.is_call = (op == rv64_pkg::op_jal || op == rv64_pkg::op_jalr) && rd_l;
		e.uop.is_return = (op == rv64_pkg::op_jalr) && rs1_l && !rd_l;
		e.pred_valid = 1'b0;
		e.pred_target = '0;
		if (e.uop.is_call) begin
			ras_top = (ras_top + 1) % `RAS_DEPTH;
			ras_mem[ras_top] = pc + 64'd4;
			if (ras_count < `RAS_DEPTH)
				ras_count++;
		end else if (e.uop.is_return && ras_count > 0) begin
			e.pred_valid = 1'b1;
			e.pred_target = ras_mem[ras_top];
			ras_top = (ras_top + `RAS_DEPTH - 1) % `RAS_DEPTH;
			ras_count--;
		end
		@(posedge clk_i);
		instr_valid_i <= 1'b1;
		instr_i <= word;
		pc_i <= pc;
		e.stamp = cyc + 3;
		exp_q.push_back(e);
		pc = pc + 64'd4;
	endtask

	task automatic gap(input int n);
		repeat (n) begin
			@(posedge clk_i);
			instr_valid_i <= 1'b0;
		end
	endtask

	task automatic drain();
		int waited;
		gap(1);
		waited = 0;
		while (exp_q.size() != 0 && waited < 8) begin
			@(posedge clk_i);
			waited++;
		end
		if (exp_q.size() != 0)
			fail("an expected result never arrived on op_o");
	endtask

	task automatic do_call(input logic [4:0] rd);
		logic [31:0] r;
		r = $urandom;
		issue(enc_j({r[20:1], 1'b0}, rd), rv64_pkg::op_jal, rv64_pkg::cls_ctltran,
			sext(64'({r[20:1], 1'b0}), 21), 1'b0);
	endtask

	task automatic do_ret(input logic [4:0] rs1);
		logic [31:0] r;
		r = $urandom;
		issue(enc_i(r[11:0], rs1, 3'b000, 5'd0, OPC_JALR), rv64_pkg::op_jalr,
			rv64_pkg::cls_ctltran, sext(64'(r[11:0]), 12), 1'b0);
	endtask

	task automatic test_int_ops();
		rv64_pkg::op_e opi[8] = '{rv64_pkg::op_addi, rv64_pkg::op_slli, rv64_pkg::op_slti,
			rv64_pkg::op_sltiu, rv64_pkg::op_xori, rv64_pkg::op_srli, rv64_pkg::op_ori,
			rv64_pkg::op_andi};
		rv64_pkg::op_e opr[8] = '{rv64_pkg::op_add, rv64_pkg::op_sll, rv64_pkg::op_slt,
			rv64_pkg::op_sltu, rv64_pkg::op_xor, rv64_pkg::op_srl, rv64_pkg::op_or,
			rv64_pkg::op_and};
		logic [31:0] r;
		logic [11:0] imm;
		for (int i = 0; i < 8; i++) begin
			r = $urandom;
			// shifts carry a 6-bit shamt in the I immediate
			imm = (i == 1 || i == 5) ? {6'b000000, r[5:0]} : r[11:0];
			issue(enc_i(imm, rreg(), 3'(i), rreg(), OPC_OP_IMM), opi[i],
				rv64_pkg::cls_intcomp, sext(64'(imm), 12), 1'b0);
			issue(enc_r(7'b0000000, rreg(), rreg(), 3'(i), rreg(), OPC_OP), opr[i],
				rv64_pkg::cls_intcomp, '0, 1'b0);
		end
		r = $urandom;
		imm = {6'b010000, r[5:0]};
		issue(enc_i(imm, rreg(), 3'b101, rreg(), OPC_OP_IMM), rv64_pkg::op_srai,
			rv64_pkg::cls_intcomp, sext(64'(imm), 12), 1'b0);
		issue(enc_r(7'b0100000, rreg(), rreg(), 3'b000, rreg(), OPC_OP), rv64_pkg::op_sub,
			rv64_pkg::cls_intcomp, '0, 1'b0);
		issue(enc_r(7'b0100000, rreg(), rreg(), 3'b101, rreg(), OPC_OP), rv64_pkg::op_sra,
			rv64_pkg::cls_intcomp, '0, 1'b0);
		issue(enc_i(r[23:12], rreg(), 3'b000, rreg(), OPC_IMM32), rv64_pkg::op_addiw,
			rv64_pkg::cls_intcomp, sext(64'(r[23:12]), 12), 1'b1);
		imm = {7'b0000000, r[28:24]};
		issue(enc_i(imm, rreg(), 3'b001, rreg(), OPC_IMM32), rv64_pkg::op_slliw,
			rv64_pkg::cls_intcomp, sext(64'(imm), 12), 1'b1);
		issue(enc_i(imm, rreg(), 3'b101, rreg(), OPC_IMM32), rv64_pkg::op_srliw,
			rv64_pkg::cls_intcomp, sext(64'(imm), 12), 1'b1);
		imm = {7'b0100000, r[28:24]};
		issue(enc_i(imm, rreg(), 3'b101, rreg(), OPC_IMM32), rv64_pkg::op_sraiw,
			rv64_pkg::cls_intcomp, sext(64'(imm), 12), 1'b1);
		issue(enc_r(7'b0000000, rreg(), rreg(), 3'b000, rreg(), OPC_OP32), rv64_pkg::op_addw,
			rv64_pkg::cls_intcomp, '0, 1'b1);
		issue(enc_r(7'b0100000, rreg(), rreg(), 3'b000, rreg(), OPC_OP32), rv64_pkg::op_subw,
			rv64_pkg::cls_intcomp, '0, 1'b1);
		issue(enc_r(7'b0000000, rreg(), rreg(), 3'b001, rreg(), OPC_OP32), rv64_pkg::op_sllw,
			rv64_pkg::cls_intcomp, '0, 1'b1);
		issue(enc_r(7'b0000000, rreg(), rreg(), 3'b101, rreg(), OPC_OP32), rv64_pkg::op_srlw,
			rv64_pkg::cls_intcomp, '0, 1'b1);
		issue(enc_r(7'b0100000, rreg(), rreg(), 3'b101, rreg(), OPC_OP32), rv64_pkg::op_sraw,
			rv64_pkg::cls_intcomp, '0, 1'b1);
		drain();
	endtask

	task automatic test_mem_ctl();
		rv64_pkg::op_e opl[7] = '{rv64_pkg::op_lb, rv64_pkg::op_lh, rv64_pkg::op_lw,
			rv64_pkg::op_ld, rv64_pkg::op_lbu, rv64_pkg::op_lhu, rv64_pkg::op_lwu};
		rv64_pkg::op_e ops[4] = '{rv64_pkg::op_sb, rv64_pkg::op_sh, rv64_pkg::op_sw,
			rv64_pkg::op_sd};
		rv64_pkg::op_e opb[6] = '{rv64_pkg::op_beq, rv64_pkg::op_bne, rv64_pkg::op_blt,
			rv64_pkg::op_bge, rv64_pkg::op_bltu, rv64_pkg::op_bgeu};
		logic [2:0]  bf3[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		logic [31:0] r;
		logic [11:0] i12;
		logic [12:0] b13;
		logic [19:0] u20;
		logic [20:0] j21;
		// s selects the sign bit of every immediate
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < 7; i++) begin
				r = $urandom;
				i12 = {1'(s), r[10:0]};
				issue(enc_i(i12, rreg(), 3'(i), rreg(), OPC_LOAD), opl[i],
					rv64_pkg::cls_lodstru, sext(64'(i12), 12), 1'b0);
			end
			for (int i = 0; i < 4; i++) begin
				r = $urandom;
				i12 = {1'(s), r[10:0]};
				issue(enc_s(i12, rreg(), rreg(), 3'(i), OPC_STORE), ops[i],
					rv64_pkg::cls_lodstru, sext(64'(i12), 12), 1'b0);
			end
			for (int i = 0; i < 6; i++) begin
				r = $urandom;
				b13 = {1'(s), r[11:0]} & 13'h1ffe;
				issue(enc_b(b13, rreg(), rreg(), bf3[i]), opb[i],
					rv64_pkg::cls_ctltran, sext(64'(b13), 13), 1'b0);
			end
			r = $urandom;
			u20 = {1'(s), r[18:0]};
			issue({u20, rreg(), OPC_LUI}, rv64_pkg::op_lui, rv64_pkg::cls_intcomp,
				sext(64'({u20, 12'h000}), 32), 1'b0);
			issue({u20, rreg(), OPC_AUIPC}, rv64_pkg::op_auipc, rv64_pkg::cls_intcomp,
				sext(64'({u20, 12'h000}), 32), 1'b0);
			// x0 and x10 keep these jumps off the return stack
			j21 = {1'(s), r[19:0]} & 21'h1ffffe;
			issue(enc_j(j21, 5'd0), rv64_pkg::op_jal, rv64_pkg::cls_ctltran,
				sext(64'(j21), 21), 1'b0);
			i12 = {1'(s), r[30:20]};
			issue(enc_i(i12, 5'd10, 3'b000, 5'd0, OPC_JALR), rv64_pkg::op_jalr,
				rv64_pkg::cls_ctltran, sext(64'(i12), 12), 1'b0);
		end
		drain();
	endtask

	task automatic test_sys_illegal();
		rv64_pkg::op_e opc[6] = '{rv64_pkg::op_csrrw, rv64_pkg::op_csrrs, rv64_pkg::op_csrrc,
			rv64_pkg::op_csrrwi, rv64_pkg::op_csrrsi, rv64_pkg::op_csrrci};
		logic [2:0]  cf3[6] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
		logic [6:0]  bad[8] = '{7'b1000011, 7'b1000111, 7'b1001011, 7'b1001111,
			7'b1010011, 7'b0001011, 7'b1101011, 7'b0010000};
		logic [31:0] r;
		issue(enc_i(12'h0ff, 5'd0, 3'b000, 5'd0, OPC_MISC), rv64_pkg::op_fence,
			rv64_pkg::cls_envcall, '0, 1'b0);
		issue(enc_i(12'h000, 5'd0, 3'b001, 5'd0, OPC_MISC), rv64_pkg::op_fence_i,
			rv64_pkg::cls_envcall, '0, 1'b0);
		issue(32'h0000_0073, rv64_pkg::op_ecall, rv64_pkg::cls_envcall, '0, 1'b0);
		issue(32'h0010_0073, rv64_pkg::op_ebreak, rv64_pkg::cls_envcall, '0, 1'b0);
		for (int i = 0; i < 6; i++) begin
			r = $urandom;
			issue(enc_i(r[11:0], rreg(), cf3[i], rreg(), OPC_SYSTEM), opc[i],
				rv64_pkg::cls_envcall, '0, 1'b0);
		end
		// multiply extension funct7 is not part of RV64I
		issue(enc_r(7'b0000001, rreg(), rreg(), 3'b000, rreg(), OPC_OP), rv64_pkg::op_none,
			rv64_pkg::cls_illegal, '0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			r = $urandom;
			issue({r[31:7], bad[i]}, rv64_pkg::op_none, rv64_pkg::cls_illegal, '0, 1'b0);
		end
		drain();
	endtask

	task automatic test_back_to_back();
		logic [31:0] r;
		for (int i = 0; i < 6; i++) begin
			r = $urandom;
			issue(enc_i(r[11:0], rreg(), 3'b000, rreg(), OPC_OP_IMM), rv64_pkg::op_addi,
				rv64_pkg::cls_intcomp, sext(64'(r[11:0]), 12), 1'b0);
		end
		for (int g = 1; g < 4; g++) begin
			r = $urandom;
			issue(enc_i(r[11:0], rreg(), 3'b111, rreg(), OPC_OP_IMM), rv64_pkg::op_andi,
				rv64_pkg::cls_intcomp, sext(64'(r[11:0]), 12), 1'b0);
			gap(g);
		end
		drain();
	endtask

	task automatic test_return_pred();
		// nested calls through both link registers
		do_call(5'd1);
		do_call(5'd5);
		do_ret(5'd5);
		gap(1);
		do_ret(5'd1);
		do_ret(5'd1);
		drain();
		// one call more than the depth loses the oldest entry
		for (int i = 0; i < `RAS_DEPTH + 1; i++)
			do_call((i % 2 == 0) ? 5'd1 : 5'd5);
		for (int i = 0; i < `RAS_DEPTH + 1; i++)
			do_ret(5'd1);
		drain();
	endtask

	task automatic test_reset_mid();
		do_call(5'd1);
		drain();
		// a call and a return in flight when reset hits
		@(posedge clk_i);
		instr_valid_i <= 1'b1;
		instr_i <= enc_j(21'h000100, 5'd1);
		pc_i <= pc;
		@(posedge clk_i);
		instr_i <= enc_i(12'h000, 5'd1, 3'b000, 5'd0, OPC_JALR);
		pc_i <= pc + 64'd4;
		rst_i <= 1'b1;
		@(posedge clk_i);
		instr_valid_i <= 1'b0;
		@(posedge clk_i);
		rst_i <= 1'b0;
		pc = pc + 64'd8;
		ras_count = 0;
		ras_top = 0;
		@(negedge clk_i);
		if (op_valid_o !== 1'b0 || pred_valid_o !== 1'b0)
			fail("valid outputs still high after reset");
		do_ret(5'd1);
		drain();
	endtask

	initial begin
		void'($urandom(47));
		rst_i = 1'b1;
		instr_valid_i = 1'b0;
		instr_i = '0;
		pc_i = '0;
		repeat (16) @(posedge clk_i);
		rst_i <= 1'b0;
		gap(2);
		test_int_ops();
		test_mem_ctl();
		test_sys_illegal();
		test_back_to_back();
		test_return_pred();
		test_reset_mid();
		gap(4);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
rtl/rv64_pkg.sv
rtl/decoder.sv
rtl/ras.sv
rtl/decode_stage.sv
testbench/decode_stage_props.sv
testbench/tb_decode_stage.sv

//--- run.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it into sim.log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_decode_stage \
	-Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"
